//--- design/lane_deserializer.sv
/*
 * Lane deserializer
 * Shifts in one serial bit per clock, first bit ending in the MSB,
 * and presents a parallel word with a one-cycle valid per word
 */

`timescale 1ns/1ps

module lane_deserializer
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  logic      fabric_clk_div,
    input  logic      reset_buf_n,
    input  logic      lane_run,         // From the lock sequencer
    input  logic      serial_in,        // One bit per clock
    output lane_out_t lane_out
);

    bit_cnt_t   bit_cnt_q;              // Bits already in shift_q
    lane_word_t shift_q;                // Serial history
    lane_word_t shift_next;             // History including this bit
    lane_word_t word_q;                 // Held until the next word
    logic       valid_q;
    logic       word_done;              // This edge takes the last bit

    // ************************************************************
    // Bit position
    // ************************************************************

    assign shift_next = {shift_q[word_width-2:0], serial_in};
    assign word_done  = lane_run && (bit_cnt_q == bit_cnt_t'(word_width - 1));

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
        end else if (!lane_run || word_done) begin
            bit_cnt_q <= '0;                            // Idle or wrap
        end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    // ************************************************************
    // Shift and word registers
    // ************************************************************

    // Older bits move toward the MSB
    always_ff @(posedge fabric_clk_div) begin
        if (lane_run) begin
            shift_q <= shift_next;
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (word_done) begin
            word_q <= shift_next;                       // Complete word
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_done;                       // High for the next cycle only
        end
    end

    assign lane_out = '{word: word_q, valid: valid_q};

    // ************************************************************
    // Assertions
    // ************************************************************

    a_valid_single : assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        valid_q |=> !valid_q)
        else $error("lane valid held for two cycles");

endmodule

//--- design/rx_cfg_pkg.sv
/*
 * Receiver configuration
 * Lane count, deserialization ratio and the lock settle time
 */

package rx_cfg_pkg;

    // ************************************************************
    // Datapath size
    // ************************************************************

    localparam int lane_count = 4;                      // Serial lanes
    localparam int word_width = 4;                      // Bits per parallel word

    // ************************************************************
    // Lock sequencing
    // ************************************************************

    localparam int settle_count = 255;                  // Clocks of stable lock before ready
    localparam int settle_cnt_width = 8;                // Holds settle_count

    // Counter widths
    localparam int bit_cnt_width = $clog2(word_width);  // Bit position within a word

endpackage

//--- design/rx_lock_sequencer.sv
/*
 * Lock sequencer
 * Holds the lanes idle until PLL lock has stayed high for the
 * settle period, then raises ready and lets the lanes run
 */

`timescale 1ns/1ps

module rx_lock_sequencer
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  logic fabric_clk_div,
    input  logic reset_buf_n,
    input  logic pll_lock,          // Level from the PLL
    input  logic enable_n,          // Active low lane enable
    output logic lane_run,          // To every lane
    output logic ready              // To capture and top output
);

    seq_state_t  state_q;
    seq_state_t  state_d;
    settle_cnt_t settle_cnt_q;      // Edges seen in settling

    // ************************************************************
    // FSM
    // ************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            wait_lock: begin
                if (pll_lock) begin
                    state_d = settling;                 // First edge with lock
                end
            end
            settling: begin
                if (!pll_lock) begin
                    state_d = wait_lock;                // Lock glitch restarts
                end else if (settle_cnt_q == settle_cnt_t'(settle_count - 1)) begin
                    state_d = running;
                end
            end
            running: begin
                if (!pll_lock) begin
                    state_d = wait_lock;                // Drop on the same edge
                end
            end
            default: state_d = wait_lock;
        endcase
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q <= wait_lock;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts only while settling with lock still high
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_cnt_q <= '0;
        end else if (state_q == settling && pll_lock) begin
            settle_cnt_q <= settle_cnt_q + 1'b1;
        end else begin
            settle_cnt_q <= '0;                         // Fresh count on every entry
        end
    end

    assign ready    = (state_q == running);
    assign lane_run = ready & ~enable_n;                // Enable gates lanes only

    // ************************************************************
    // Assertions
    // ************************************************************

    a_ready_after_lock : assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        ready |-> $past(pll_lock))
        else $error("ready high without lock on the previous edge");

    a_run_needs_ready : assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        lane_run |-> ready)
        else $error("lane_run high while not ready");

endmodule

//--- design/rx_types_pkg.sv
/*
 * Receiver types
 * Counter and word vectors, lane and frame output structs,
 * and the lock sequencer states
 */

package rx_types_pkg;

    import rx_cfg_pkg::*;

    // ************************************************************
    // Plain vectors
    // ************************************************************

    typedef logic [settle_cnt_width-1:0] settle_cnt_t;  // Lock settle counter
    typedef logic [bit_cnt_width-1:0]    bit_cnt_t;     // Bits taken in so far
    typedef logic [word_width-1:0]       lane_word_t;   // One deserialized word

    // ************************************************************
    // Bundles
    // ************************************************************

    // Output of one lane deserializer
    typedef struct packed {
        lane_word_t word;                               // First bit in MSB
        logic       valid;                              // One cycle per word
    } lane_out_t;

    // Captured frame across all lanes
    typedef struct packed {
        lane_word_t [lane_count-1:0] words;             // Index matches lane
        logic                        strobe;            // Pulses on each load
    } frame_t;

    // Lock sequencer FSM
    typedef enum logic [1:0] {
        wait_lock,                                      // Lock low
        settling,                                       // Counting stable lock
        running                                         // Lanes may run
    } seq_state_t;

endpackage

//--- design/rx_word_capture.sv
/*
 * Word capture
 * Loads every lane word together when the lanes are valid and
 * ready is high, and strobes once per captured frame
 */

`timescale 1ns/1ps

module rx_word_capture
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  logic                       fabric_clk_div,
    input  logic                       reset_buf_n,
    input  logic                       ready,       // Lock sequencer level
    input  lane_out_t [lane_count-1:0] lane_bus,    // One element per lane
    output frame_t                     frame
);

    lane_word_t [lane_count-1:0] words_q;           // Last captured frame
    logic                        strobe_q;
    logic                        load;
    logic [lane_count-1:0]       lane_valid;        // Gathered for the check

    // ************************************************************
    // Capture
    // ************************************************************

    // Lanes share lane_run, so lane 0 times the whole frame
    assign load = lane_bus[0].valid & ready;

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            lane_valid[i] = lane_bus[i].valid;
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            words_q  <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= load;                           // Marks each load
            if (load) begin
                for (int i = 0; i < lane_count; i++) begin
                    words_q[i] <= lane_bus[i].word;
                end
            end                                         // Else hold, words dropped
        end
    end

    assign frame = '{words: words_q, strobe: strobe_q};

    // ************************************************************
    // Assertions
    // ************************************************************

    // All lanes must agree with lane 0 on word timing
    a_valid_aligned : assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        (lane_valid == {lane_count{lane_valid[0]}}))
        else $error("lane valids out of step: %b", lane_valid);

endmodule

//--- design/serdes_rx_top.sv
/*
 * Multi-lane serial receiver
 * Lock sequencer, one deserializer per lane and the word capture
 */

`timescale 1ns/1ps

module serdes_rx_top
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  logic                  fabric_clk_div,
    input  logic                  reset_buf_n,
    input  logic                  pll_lock,     // External PLL lock
    input  logic                  enable_n,     // Active low
    input  logic [lane_count-1:0] serial_in,    // Bit i feeds lane i
    output frame_t                frame,
    output logic                  ready
);

    logic                       lane_run;       // Shared by all lanes
    lane_out_t [lane_count-1:0] lane_bus;

    // ************************************************************
    // Lock sequencing
    // ************************************************************

    rx_lock_sequencer rx_lock_sequencer_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .pll_lock       (pll_lock),
        .enable_n       (enable_n),
        .lane_run       (lane_run),
        .ready          (ready)
    );

    // ************************************************************
    // Lanes
    // ************************************************************

    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        lane_deserializer lane_deserializer_inst (
            .fabric_clk_div (fabric_clk_div),
            .reset_buf_n    (reset_buf_n),
            .lane_run       (lane_run),
            .serial_in      (serial_in[i]),
            .lane_out       (lane_bus[i])
        );
    end

    // Frame output
    rx_word_capture rx_word_capture_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .ready          (ready),
        .lane_bus       (lane_bus),
        .frame          (frame)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receiver testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module serdes_rx_tb \
    -Mdir obj_dir -o serdes_rx_sim \
    && ./obj_dir/serdes_rx_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null

grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- src.f
design/rx_cfg_pkg.sv
design/rx_types_pkg.sv
design/rx_lock_sequencer.sv
design/lane_deserializer.sv
design/rx_word_capture.sv
design/serdes_rx_top.sv
test/serdes_rx_tb.sv

//--- test/serdes_rx_tb.sv
/*
 * Receiver testbench
 * Random serial stimulus on every lane, a lock and enable sequence,
 * and a reference model that the concurrent assertions compare against
 */

`timescale 1ns/1ps

module serdes_rx_tb
    import rx_cfg_pkg::*, rx_types_pkg::*;
();

    logic                  fabric_clk_div;
    logic                  reset_buf_n;
    logic                  pll_lock;
    logic                  enable_n;
    logic [lane_count-1:0] serial_in;
    frame_t                frame;
    logic                  ready;

    logic [31:0] rnd_bits;                              // Raw random draw
    int          errors = 0;
    int          timeouts = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          mark;                                  // Problems before a test

    // Reference model state
    int                          lock_cnt;              // Consecutive edges with lock high
    logic                        exp_ready;
    int                          run_bits;              // Bit position within a word
    lane_word_t [lane_count-1:0] hist;                  // Per lane serial history
    logic                        word_due;              // Word finished on the last edge
    lane_word_t [lane_count-1:0] due_words;
    frame_t                      exp_frame;

    serdes_rx_top serdes_rx_top_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .pll_lock       (pll_lock),
        .enable_n       (enable_n),
        .serial_in      (serial_in),
        .frame          (frame),
        .ready          (ready)
    );

    initial begin
        fabric_clk_div = 1'b0;
        forever begin
            #20 fabric_clk_div = ~fabric_clk_div;       // 40 ns period
        end
    end

    // New random bits on every lane each clock
    initial begin
        rnd_bits = $urandom(32'h4d93);                  // Seed once
        forever begin
            @(posedge fabric_clk_div);
            rnd_bits = $urandom;
            serial_in <= rnd_bits[lane_count-1:0];
        end
    end

    // ************************************************************
    // Reference model
    // ************************************************************

    always @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            lock_cnt  <= 0;
            exp_ready <= 1'b0;
            run_bits  <= 0;
            word_due  <= 1'b0;
            exp_frame <= '0;
            hist      <= '0;
        end else begin
            if (!pll_lock) begin
                lock_cnt  <= 0;                         // Lost lock restarts settle
                exp_ready <= 1'b0;
            end else begin
                if (lock_cnt <= settle_count) begin
                    lock_cnt <= lock_cnt + 1;           // Saturates past settle
                end
                exp_ready <= (lock_cnt + 1 > settle_count);
            end
            if (exp_ready && !enable_n) begin           // Lanes running this edge
                for (int i = 0; i < lane_count; i++) begin
                    hist[i] <= {hist[i][word_width-2:0], serial_in[i]};
                    if (run_bits == word_width - 1) begin
                        due_words[i] <= {hist[i][word_width-2:0], serial_in[i]};
                    end
                end
                run_bits <= (run_bits + 1) % word_width;
                word_due <= (run_bits == word_width - 1);
            end else begin
                run_bits <= 0;                          // Next word starts fresh
                word_due <= 1'b0;
            end
            exp_frame.strobe <= word_due && exp_ready;
            if (word_due && exp_ready) begin
                for (int i = 0; i < lane_count; i++) begin
                    exp_frame.words[i] <= due_words[i];
                end
            end                                         // Else words hold
        end
    end

    // ************************************************************
    // Checks
    // ************************************************************

    task automatic note_error(input string msg);
        errors++;
        $display("** Error: %0t ns: %s", $time, msg);
    endtask

    a_reset_clear : assert property (@(posedge fabric_clk_div)
        $rose(reset_buf_n) |-> (!ready && !frame.strobe && frame.words == '0))
        else note_error("outputs not cleared after reset");

    a_ready_match : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        ready == exp_ready)
        else note_error($sformatf("ready is %b, expected %b",
                                  $sampled(ready), $sampled(exp_ready)));

    a_strobe_match : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        frame.strobe == exp_frame.strobe)
        else note_error($sformatf("strobe is %b, expected %b",
                                  $sampled(frame.strobe), $sampled(exp_frame.strobe)));

    a_words_match : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        frame.words == exp_frame.words)
        else note_error($sformatf("words are %h, expected %h",
                                  $sampled(frame.words), $sampled(exp_frame.words)));

    // Lanes held off never strobe, whatever the model holds
    a_idle_no_strobe : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        (enable_n && $past(enable_n) && $past(enable_n, 2)) |-> !frame.strobe)
        else note_error("strobe seen while lanes were disabled");

    // ************************************************************
    // Sequencing helpers
    // ************************************************************

    task automatic wait_ready(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (ready !== level && n < limit) begin
            @(negedge fabric_clk_div);                  // Outputs settled here
            n++;
        end
        if (ready !== level) begin
            timeouts++;
            $display("Timeout: %s did not happen within %0d clocks", what, limit);
        end
    endtask

    task automatic wait_strobes(input int count, input int limit, input string what);
        int n;
        int seen;
        n = 0;
        seen = 0;
        while (seen < count && n < limit) begin
            @(negedge fabric_clk_div);
            if (frame.strobe) begin
                seen++;
            end
            n++;
        end
        if (seen < count) begin
            timeouts++;
            $display("Timeout: only %0d of %0d %s within %0d clocks", seen, count, what, limit);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors + timeouts > mark) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
        mark = errors + timeouts;
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        reset_buf_n = 1'b0;
        pll_lock    = 1'b0;
        enable_n    = 1'b1;
        serial_in   = '0;
        mark        = 0;
        repeat (16) @(posedge fabric_clk_div);
        reset_buf_n <= 1'b1;
        repeat (4) @(posedge fabric_clk_div);
        finish_test("reset values");

        repeat (300) @(posedge fabric_clk_div);         // Ready must stay low without lock
        pll_lock <= 1'b1;
        enable_n <= 1'b0;
        wait_ready(1'b1, 300, "ready rising after lock");
        finish_test("lock settle");

        wait_strobes(8, 60, "frame strobes while running");
        finish_test("running frames");

        @(posedge fabric_clk_div);
        enable_n <= 1'b1;
        repeat (25) @(posedge fabric_clk_div);
        enable_n <= 1'b0;
        wait_strobes(3, 30, "frame strobes after enable");
        finish_test("enable gating");

        @(posedge fabric_clk_div);
        pll_lock <= 1'b0;
        wait_ready(1'b0, 4, "ready falling after lock loss");
        repeat (12) @(posedge fabric_clk_div);          // Words must hold
        pll_lock <= 1'b1;
        wait_ready(1'b1, 300, "ready rising after relock");
        wait_strobes(3, 30, "frame strobes after relock");
        finish_test("lock loss and relock");

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d timeouts",
                 tests_run, tests_failed, errors, timeouts);
        if (tests_failed == 0 && errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
